// ==== hdl/mipsPkg.sv ====
//----------------------------------------------------------
// MIPS core shared types
// Instruction formats, opcode and funct values, ALU operations
// and the control structs carried down the pipeline
//----------------------------------------------------------
package mipsPkg;

  typedef logic [31:0] word;
  typedef logic [4:0]  regIndex;

  // Three views of one instruction word
  typedef struct packed {
    logic [5:0] op;
    regIndex    rs;
    regIndex    rt;
    regIndex    rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFields;

  typedef struct packed {
    logic [5:0]  op;
    regIndex     rs;
    regIndex     rt;
    logic [15:0] imm;
  } iFields;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target;
  } jFields;

  typedef union packed {
    rFields rFormat;
    iFields iFormat;
    jFields jFormat;
  } instrWord;

  //----------------------------------------------------------
  // Opcodes
  //----------------------------------------------------------
  localparam logic [5:0] opRtype = 6'b000000;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opBne   = 6'b000101;
  localparam logic [5:0] opAddi  = 6'b001000;
  localparam logic [5:0] opAddiu = 6'b001001;
  localparam logic [5:0] opSlti  = 6'b001010;
  localparam logic [5:0] opAndi  = 6'b001100;
  localparam logic [5:0] opOri   = 6'b001101;
  localparam logic [5:0] opXori  = 6'b001110;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;

  // R-type funct field
  localparam logic [5:0] functAdd  = 6'b100000;
  localparam logic [5:0] functAddu = 6'b100001;
  localparam logic [5:0] functSub  = 6'b100010;
  localparam logic [5:0] functSubu = 6'b100011;
  localparam logic [5:0] functAnd  = 6'b100100;
  localparam logic [5:0] functOr   = 6'b100101;
  localparam logic [5:0] functXor  = 6'b100110;
  localparam logic [5:0] functNor  = 6'b100111;
  localparam logic [5:0] functSlt  = 6'b101010;
  localparam logic [5:0] functSltu = 6'b101011;

  typedef enum logic [2:0] {
    aluAnd  = 3'b000,
    aluOr   = 3'b001,
    aluAdd  = 3'b010,
    aluSltu = 3'b011,
    aluXor  = 3'b100,
    aluNor  = 3'b101,
    aluSub  = 3'b110,
    aluSlt  = 3'b111
  } aluOp;

  //----------------------------------------------------------
  // Pipeline control
  //----------------------------------------------------------
  typedef struct packed {
    logic regWrite;
    logic regDst;     // Write rd instead of rt
    logic aluSrc;     // Second operand is the immediate
    logic memWrite;
    logic memToReg;
    logic zeroExt;
    aluOp alu;
    logic branch;
    logic branchNe;
    logic jump;
  } decodeCtrl;

  typedef struct packed {
    logic regWrite;
    logic regDst;
    logic aluSrc;
    logic memWrite;
    logic memToReg;
    aluOp alu;
  } execCtrl;

  typedef struct packed {
    execCtrl ctrl;
    word     srcA;
    word     srcB;
    word     imm;    // Already extended
    regIndex rs;
    regIndex rt;
    regIndex rd;
  } decodedOp;

  typedef struct packed {
    logic regWrite;
    logic memToReg;
  } memCtrl;

endpackage

// ==== hdl/controlDecoder.sv ====
//----------------------------------------------------------
// Control decoder
// Maps opcode and funct to the decode-stage control word
//----------------------------------------------------------
`timescale 1ns/1ps

module controlDecoder (
  input  mipsPkg::instrWord  instr,
  output mipsPkg::decodeCtrl ctrl
);
  import mipsPkg::*;

  always_comb begin
    ctrl     = '0;         // Unknown opcodes fall through as no-ops
    ctrl.alu = aluAdd;
    case (instr.rFormat.op)
      opRtype: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;
        case (instr.rFormat.funct)
          functAdd, functAddu: ctrl.alu = aluAdd;   // No overflow trap
          functSub, functSubu: ctrl.alu = aluSub;
          functAnd:            ctrl.alu = aluAnd;
          functOr:             ctrl.alu = aluOr;
          functXor:            ctrl.alu = aluXor;
          functNor:            ctrl.alu = aluNor;
          functSlt:            ctrl.alu = aluSlt;
          functSltu:           ctrl.alu = aluSltu;
          default:             ctrl.regWrite = 1'b0;
        endcase
      end
      opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      opAddi, opAddiu: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      opSlti: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.alu      = aluSlt;
      end
      opAndi, opOri, opXori: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.zeroExt  = 1'b1;
        case (instr.rFormat.op)
          opAndi:  ctrl.alu = aluAnd;
          opOri:   ctrl.alu = aluOr;
          default: ctrl.alu = aluXor;
        endcase
      end
      opBeq: ctrl.branch = 1'b1;
      opBne: begin
        ctrl.branch   = 1'b1;
        ctrl.branchNe = 1'b1;
      end
      opJ: ctrl.jump = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== hdl/registerFile.sv ====
//----------------------------------------------------------
// Register file, 32 x 32
// Two combinational reads, one write on the falling edge
//----------------------------------------------------------
`timescale 1ns/1ps

module registerFile (
  input  logic             clk,
  input  mipsPkg::regIndex readA,
  input  mipsPkg::regIndex readB,
  output mipsPkg::word     dataA,
  output mipsPkg::word     dataB,
  input  logic             writeEn,
  input  mipsPkg::regIndex writeAddr,
  input  mipsPkg::word     writeData
);
  import mipsPkg::*;

  word regs [32];

  // Falling edge so decode sees writeback in the same cycle
  always_ff @(negedge clk) begin
    if (writeEn) regs[writeAddr] <= writeData;
  end

  assign dataA = (readA == '0) ? '0 : regs[readA];  // $0 is hardwired
  assign dataB = (readB == '0) ? '0 : regs[readB];

endmodule

// ==== hdl/hazardUnit.sv ====
//----------------------------------------------------------
// Hazard unit
// Forwarding selects for decode and execute, stall detection
//----------------------------------------------------------
`timescale 1ns/1ps

module hazardUnit (
  input  mipsPkg::regIndex rsD,
  input  mipsPkg::regIndex rtD,
  input  mipsPkg::regIndex rsE,
  input  mipsPkg::regIndex rtE,
  input  mipsPkg::regIndex writeRegE,
  input  mipsPkg::regIndex writeRegM,
  input  mipsPkg::regIndex writeRegW,
  input  logic             regWriteE,
  input  logic             regWriteM,
  input  logic             regWriteW,
  input  logic             memToRegE,
  input  logic             memToRegM,
  input  logic             branchD,
  output logic             forwardAD,
  output logic             forwardBD,
  output logic [1:0]       forwardAE,
  output logic [1:0]       forwardBE,
  output logic             stall
);
  import mipsPkg::*;

  logic loadUseStall;
  logic branchStall;

  // Branch compare takes the memory-stage ALU value
  assign forwardAD = (rsD != '0) && (rsD == writeRegM) && regWriteM;
  assign forwardBD = (rtD != '0) && (rtD == writeRegM) && regWriteM;

  // Memory stage (2'b10) beats writeback (2'b01) as the newer value
  always_comb begin
    forwardAE = 2'b00;
    forwardBE = 2'b00;
    if (rsE != '0) begin
      if (rsE == writeRegM && regWriteM)      forwardAE = 2'b10;
      else if (rsE == writeRegW && regWriteW) forwardAE = 2'b01;
    end
    if (rtE != '0) begin
      if (rtE == writeRegM && regWriteM)      forwardBE = 2'b10;
      else if (rtE == writeRegW && regWriteW) forwardBE = 2'b01;
    end
  end

  assign loadUseStall = memToRegE && (rtE == rsD || rtE == rtD);

  // Result not ready for the compare yet
  assign branchStall = branchD &&
    ((regWriteE && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD)) ||
     (memToRegM && writeRegM != '0 && (writeRegM == rsD || writeRegM == rtD)));

  assign stall = loadUseStall || branchStall;

endmodule

// ==== hdl/fetchDecodeStage.sv ====
//----------------------------------------------------------
// Fetch and decode stages
// PC, F/D register, branch resolution and operand packing
//----------------------------------------------------------
`timescale 1ns/1ps

module fetchDecodeStage (
  input  logic               clk,
  input  logic               reset,
  input  mipsPkg::word       instr,
  output mipsPkg::word       pc,
  input  logic               stall,
  input  mipsPkg::decodeCtrl ctrl,
  output mipsPkg::instrWord  instrD,
  input  mipsPkg::word       dataA,
  input  mipsPkg::word       dataB,
  input  logic               forwardAD,
  input  logic               forwardBD,
  input  mipsPkg::word       aluOutM,
  output mipsPkg::decodedOp  decoded
);
  import mipsPkg::*;

  word  pcD;
  word  pcPlus4;
  word  pcNext;
  word  branchTarget;
  word  jumpTarget;
  word  cmpA;
  word  cmpB;
  word  immExt;
  logic branchTaken;

  //----------------------------------------------------------
  // Fetch
  //----------------------------------------------------------
  assign pcPlus4 = pc + 32'd4;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= pcNext;
    end
  end

  // Reset leaves a no-op in decode
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      instrD <= '0;
      pcD    <= '0;
    end else if (!stall) begin
      instrD <= instr;
      pcD    <= pc;
    end
  end

  //----------------------------------------------------------
  // Decode
  //----------------------------------------------------------
  assign cmpA = forwardAD ? aluOutM : dataA;
  assign cmpB = forwardBD ? aluOutM : dataB;

  assign branchTaken = ctrl.branch && ((cmpA == cmpB) ^ ctrl.branchNe);

  // Offsets are relative to the branch itself
  assign branchTarget = pcD + {{14{instrD.iFormat.imm[15]}}, instrD.iFormat.imm, 2'b00};
  assign jumpTarget   = {pcD[31:28], instrD.jFormat.target, 2'b00};

  // Fetch already holds the delay slot, so redirect the one after it
  always_comb begin
    if (ctrl.jump)        pcNext = jumpTarget;
    else if (branchTaken) pcNext = branchTarget;
    else                  pcNext = pcPlus4;
  end

  assign immExt = ctrl.zeroExt ? {16'h0000, instrD.iFormat.imm}
                               : {{16{instrD.iFormat.imm[15]}}, instrD.iFormat.imm};

  always_comb begin
    decoded.ctrl.regWrite = ctrl.regWrite;
    decoded.ctrl.regDst   = ctrl.regDst;
    decoded.ctrl.aluSrc   = ctrl.aluSrc;
    decoded.ctrl.memWrite = ctrl.memWrite;
    decoded.ctrl.memToReg = ctrl.memToReg;
    decoded.ctrl.alu      = ctrl.alu;
    decoded.srcA          = dataA;       // Execute forwards from M and W
    decoded.srcB          = dataB;
    decoded.imm           = immExt;
    decoded.rs            = instrD.rFormat.rs;
    decoded.rt            = instrD.rFormat.rt;
    decoded.rd            = instrD.rFormat.rd;
  end

endmodule

// ==== hdl/executeStage.sv ====
//----------------------------------------------------------
// Execute stage
// D/E register, operand forwarding and the ALU
//----------------------------------------------------------
`timescale 1ns/1ps

module executeStage (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall,
  input  mipsPkg::decodedOp decoded,
  input  logic [1:0]        forwardAE,
  input  logic [1:0]        forwardBE,
  input  mipsPkg::word      resultW,
  input  mipsPkg::word      aluOutM,
  output mipsPkg::word      aluOutE,
  output mipsPkg::word      storeDataE,
  output mipsPkg::regIndex  writeRegE,
  output mipsPkg::execCtrl  ctrlE,
  output mipsPkg::regIndex  rsE,
  output mipsPkg::regIndex  rtE
);
  import mipsPkg::*;

  decodedOp opE;
  word      srcAE;
  word      srcBE;

  // A stalled decode leaves a bubble behind it
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      opE <= '0;
    end else if (stall) begin
      opE <= '0;
    end else begin
      opE <= decoded;
    end
  end

  assign ctrlE = opE.ctrl;
  assign rsE   = opE.rs;
  assign rtE   = opE.rt;

  //----------------------------------------------------------
  // Operands
  //----------------------------------------------------------
  always_comb begin
    case (forwardAE)
      2'b10:   srcAE = aluOutM;
      2'b01:   srcAE = resultW;
      default: srcAE = opE.srcA;
    endcase
    case (forwardBE)
      2'b10:   storeDataE = aluOutM;
      2'b01:   storeDataE = resultW;
      default: storeDataE = opE.srcB;
    endcase
  end

  assign srcBE     = opE.ctrl.aluSrc ? opE.imm : storeDataE;
  assign writeRegE = opE.ctrl.regDst ? opE.rd : opE.rt;

  //----------------------------------------------------------
  // ALU
  //----------------------------------------------------------
  always_comb begin
    case (opE.ctrl.alu)
      aluAnd:  aluOutE = srcAE & srcBE;
      aluOr:   aluOutE = srcAE | srcBE;
      aluAdd:  aluOutE = srcAE + srcBE;
      aluSub:  aluOutE = srcAE - srcBE;
      aluXor:  aluOutE = srcAE ^ srcBE;
      aluNor:  aluOutE = ~(srcAE | srcBE);
      aluSlt:  aluOutE = {31'b0, $signed(srcAE) < $signed(srcBE)};
      default: aluOutE = {31'b0, srcAE < srcBE};  // SLTU
    endcase
  end

endmodule

// ==== hdl/memWritebackStage.sv ====
//----------------------------------------------------------
// Memory and writeback stages
// E/M and M/W registers plus the writeback result mux
//----------------------------------------------------------
`timescale 1ns/1ps

module memWritebackStage (
  input  logic             clk,
  input  logic             reset,
  input  mipsPkg::word     aluOutE,
  input  mipsPkg::word     storeDataE,
  input  mipsPkg::regIndex writeRegE,
  input  mipsPkg::execCtrl ctrlE,
  input  mipsPkg::word     readData,
  output logic             memWrite,
  output mipsPkg::word     aluOut,
  output mipsPkg::word     writeData,
  output mipsPkg::regIndex writeRegM,
  output logic             regWriteM,
  output logic             memToRegM,
  output mipsPkg::word     resultW,
  output mipsPkg::regIndex writeRegW,
  output logic             regWriteW
);
  import mipsPkg::*;

  memCtrl ctrlM;
  memCtrl ctrlW;
  word    aluOutW;
  word    readDataW;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      memWrite  <= 1'b0;
      ctrlM     <= '0;
      ctrlW     <= '0;
      writeRegM <= '0;
      writeRegW <= '0;
    end else begin
      memWrite  <= ctrlE.memWrite;
      ctrlM     <= '{regWrite: ctrlE.regWrite, memToReg: ctrlE.memToReg};
      ctrlW     <= ctrlM;
      writeRegM <= writeRegE;
      writeRegW <= writeRegM;
    end
  end

  // Data path words
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      aluOut    <= '0;
      writeData <= '0;
      aluOutW   <= '0;
      readDataW <= '0;
    end else begin
      aluOut    <= aluOutE;
      writeData <= storeDataE;
      aluOutW   <= aluOut;
      readDataW <= readData;
    end
  end

  assign regWriteM = ctrlM.regWrite;
  assign memToRegM = ctrlM.memToReg;
  assign regWriteW = ctrlW.regWrite;
  assign resultW   = ctrlW.memToReg ? readDataW : aluOutW;

endmodule

// ==== hdl/mipsCore.sv ====
//----------------------------------------------------------
// Pipelined MIPS core
// Five stages with forwarding and decode-stage branches
//----------------------------------------------------------
`timescale 1ns/1ps

module mipsCore (
  input  logic         clk,
  input  logic         reset,
  output mipsPkg::word pc,
  input  mipsPkg::word instr,
  output logic         memWrite,
  output mipsPkg::word aluOut,     // Data address
  output mipsPkg::word writeData,
  input  mipsPkg::word readData
);
  import mipsPkg::*;

  instrWord   instrD;
  decodeCtrl  ctrlD;
  decodedOp   decodedD;
  word        dataA;
  word        dataB;
  logic       forwardAD;
  logic       forwardBD;
  logic [1:0] forwardAE;
  logic [1:0] forwardBE;
  logic       stall;
  word        aluOutE;
  word        storeDataE;
  execCtrl    ctrlE;
  regIndex    rsE;
  regIndex    rtE;
  regIndex    writeRegE;
  regIndex    writeRegM;
  regIndex    writeRegW;
  logic       regWriteM;
  logic       memToRegM;
  logic       regWriteW;
  word        resultW;

  fetchDecodeStage fetchDecode0 (
    .clk(clk), .reset(reset), .instr(instr), .pc(pc), .stall(stall),
    .ctrl(ctrlD), .instrD(instrD), .dataA(dataA), .dataB(dataB),
    .forwardAD(forwardAD), .forwardBD(forwardBD), .aluOutM(aluOut),
    .decoded(decodedD)
  );

  controlDecoder decoder0 (.instr(instrD), .ctrl(ctrlD));

  registerFile regFile0 (
    .clk(clk), .readA(instrD.rFormat.rs), .readB(instrD.rFormat.rt),
    .dataA(dataA), .dataB(dataB), .writeEn(regWriteW),
    .writeAddr(writeRegW), .writeData(resultW)
  );

  hazardUnit hazard0 (
    .rsD(instrD.rFormat.rs), .rtD(instrD.rFormat.rt), .rsE(rsE), .rtE(rtE),
    .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
    .regWriteE(ctrlE.regWrite), .regWriteM(regWriteM), .regWriteW(regWriteW),
    .memToRegE(ctrlE.memToReg), .memToRegM(memToRegM), .branchD(ctrlD.branch),
    .forwardAD(forwardAD), .forwardBD(forwardBD),
    .forwardAE(forwardAE), .forwardBE(forwardBE), .stall(stall)
  );

  executeStage execute0 (
    .clk(clk), .reset(reset), .stall(stall), .decoded(decodedD),
    .forwardAE(forwardAE), .forwardBE(forwardBE), .resultW(resultW),
    .aluOutM(aluOut), .aluOutE(aluOutE), .storeDataE(storeDataE),
    .writeRegE(writeRegE), .ctrlE(ctrlE), .rsE(rsE), .rtE(rtE)
  );

  memWritebackStage memWriteback0 (
    .clk(clk), .reset(reset), .aluOutE(aluOutE), .storeDataE(storeDataE),
    .writeRegE(writeRegE), .ctrlE(ctrlE), .readData(readData),
    .memWrite(memWrite), .aluOut(aluOut), .writeData(writeData),
    .writeRegM(writeRegM), .regWriteM(regWriteM), .memToRegM(memToRegM),
    .resultW(resultW), .writeRegW(writeRegW), .regWriteW(regWriteW)
  );

endmodule

// ==== testbench/tbClock.sv ====
//----------------------------------------------------------
// Testbench clock and reset
// 10 ns clock, reset held for 8 cycles after each restart
//----------------------------------------------------------
`timescale 1ns/1ps

module tbClock (
  input  logic restart,   // Rising edge starts a new reset
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    reset = 1'b1;           // Held until the first restart
    forever begin
      @(posedge restart);
      reset = 1'b1;
      repeat (8) @(posedge clk);
      #1 reset = 1'b0;      // Released just after an edge
    end
  end

endmodule

// ==== testbench/mipsTb.sv ====
//----------------------------------------------------------
// MIPS core testbench
// Instruction ROM and data RAM models, directed programs
// checked against a log of stores
//----------------------------------------------------------
`timescale 1ns/1ps

module mipsTb;
  import mipsPkg::*;

  localparam int  testCount     = 5;
  localparam int  cyclesPerTest = 200;
  localparam word doneAddr      = 32'h0000_00FC;  // Final store of every program

  logic clk;
  logic reset;
  logic restart;
  word  pc;
  word  instr;
  logic memWrite;
  word  aluOut;
  word  writeData;
  word  readData;

  word         rom [64];
  word         ram [64];
  int          emitIdx;
  logic        doneSeen;
  word         storeAddr [$];
  word         storeData [$];
  word         expAddr [$];
  word         expData [$];

  tbClock clock0 (.restart(restart), .clk(clk), .reset(reset));

  mipsCore dut0 (
    .clk(clk), .reset(reset), .pc(pc), .instr(instr), .memWrite(memWrite),
    .aluOut(aluOut), .writeData(writeData), .readData(readData)
  );

  //----------------------------------------------------------
  // Memory models and store log
  //----------------------------------------------------------
  assign instr    = rom[pc[7:2]];
  assign readData = ram[aluOut[7:2]];

  always @(posedge clk) begin
    if (memWrite) ram[aluOut[7:2]] <= writeData;
  end

  // Sampled mid-cycle while the memory stage is stable
  always @(negedge clk) begin
    if (memWrite) begin
      if (aluOut == doneAddr) begin
        doneSeen <= 1'b1;
      end else begin
        storeAddr.push_back(aluOut);
        storeData.push_back(writeData);
      end
    end
  end

  //----------------------------------------------------------
  // Instruction encoding
  //----------------------------------------------------------
  function automatic word rType(logic [5:0] funct, regIndex rd, regIndex rs, regIndex rt);
    return {opRtype, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic word iType(logic [5:0] op, regIndex rt, regIndex rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word jType(int target);
    return {opJ, 26'(target)};  // Word index of the target
  endfunction

  // Expected values per the instruction set
  function automatic word rResult(logic [5:0] f, word a, word b);
    case (f)
      functAdd, functAddu: return a + b;
      functSub, functSubu: return a - b;
      functAnd:            return a & b;
      functOr:             return a | b;
      functXor:            return a ^ b;
      functNor:            return ~(a | b);
      functSlt:            return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:             return (a < b) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic word iResult(logic [5:0] op, word a, logic [15:0] imm);
    word sext;
    word zext;
    sext = {{16{imm[15]}}, imm};
    zext = {16'h0000, imm};
    case (op)
      opAddi, opAddiu: return a + sext;
      opSlti:          return ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
      opAndi:          return a & zext;
      opOri:           return a | zext;
      default:         return a ^ zext;
    endcase
  endfunction

  //----------------------------------------------------------
  // Program building and running
  //----------------------------------------------------------
  task automatic emit(input word w);
    rom[emitIdx[5:0]] = w;
    emitIdx++;
  endtask

  task automatic loadWord(input regIndex rt, input int addr);
    emit(iType(opLw, rt, 5'd0, 16'(addr)));
  endtask

  task automatic storeWord(input regIndex rt, input int addr);
    emit(iType(opSw, rt, 5'd0, 16'(addr)));
  endtask

  task automatic expectStore(input word addr, input word data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  task automatic clearMemories();
    foreach (rom[i]) rom[i] = '0;                     // All NOPs
    foreach (ram[i]) ram[i] <= 32'hDA7A_0000 + i;
  endtask

  task automatic checkValue(input string name, input word expected, input word actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "Stopping at the first failing check");
    end
  endtask

  // Holds the core in reset while a new program is written
  task automatic startTest();
    @(posedge clk);
    #1 restart = 1'b1;
    clearMemories();
    storeAddr.delete();
    storeData.delete();
    expAddr.delete();
    expData.delete();
    doneSeen <= 1'b0;
    emitIdx = 0;
  endtask

  task automatic runProgram();
    storeWord(5'd0, doneAddr);
    emit(jType(emitIdx));   // Spin here
    emit('0);
    @(negedge reset);
    restart = 1'b0;
    checkValue("pc", 32'h0, pc);                 // Fetch starts at address 0
    checkValue("memWrite", 32'h0, memWrite);
    while (!doneSeen) @(posedge clk);
    checkValue("store count", expAddr.size(), storeAddr.size());
    foreach (expAddr[i]) begin
      checkValue($sformatf("store %0d address", i), expAddr[i], storeAddr[i]);
      checkValue($sformatf("store %0d data", i), expData[i], storeData[i]);
    end
  endtask

  //----------------------------------------------------------
  // Directed tests
  //----------------------------------------------------------
  task automatic rtypeAluOps();
    word        a;
    word        b;
    logic [5:0] functs [10];
    startTest();
    functs = '{functAdd, functAddu, functSub, functSubu, functAnd,
               functOr, functXor, functNor, functSlt, functSltu};
    a = $urandom;
    b = $urandom;
    ram[0] <= a;
    ram[1] <= b;
    loadWord(5'd1, 0);
    loadWord(5'd2, 4);
    foreach (functs[k]) begin
      emit(rType(functs[k], 5'd3, 5'd1, 5'd2));
      storeWord(5'd3, 'h40 + 4 * k);
      expectStore('h40 + 4 * k, rResult(functs[k], a, b));
    end
    runProgram();
  endtask

  task automatic immediateOps();
    word         a;
    logic [15:0] imm;
    logic [5:0]  ops [6];
    startTest();
    ops = '{opAddi, opAddiu, opSlti, opAndi, opOri, opXori};
    a = $urandom;
    ram[0] <= a;
    loadWord(5'd1, 0);
    foreach (ops[k]) begin
      imm = 16'($urandom);
      emit(iType(ops[k], 5'd2, 5'd1, imm));
      storeWord(5'd2, 'h40 + 4 * k);
      expectStore('h40 + 4 * k, iResult(ops[k], a, imm));
    end
    runProgram();
  endtask

  task automatic forwardingChains();
    word         a;
    word         b;
    word         r2;
    word         r3;
    word         r4;
    logic [15:0] imm;
    startTest();
    a   = $urandom;
    b   = $urandom;
    imm = 16'($urandom);
    ram[0] <= a;
    ram[1] <= b;
    r2 = a + {{16{imm[15]}}, imm};
    r3 = r2 + a;
    r4 = r3 ^ r2;
    loadWord(5'd1, 0);
    emit(iType(opAddi, 5'd2, 5'd1, imm));        // Load-use stall
    emit(rType(functAdd, 5'd3, 5'd2, 5'd1));
    emit(rType(functXor, 5'd4, 5'd3, 5'd2));
    storeWord(5'd4, 'h40);
    expectStore('h40, r4);
    storeWord(5'd3, 'h44);
    expectStore('h44, r3);
    loadWord(5'd5, 4);
    storeWord(5'd5, 'h48);                       // Loaded word as store data
    expectStore('h48, b);
    emit(rType(functOr, 5'd6, 5'd5, 5'd4));
    storeWord(5'd6, 'h4C);
    expectStore('h4C, b | r4);
    runProgram();
  endtask

  // Branch, delay slot, skipped store, then the target store
  task automatic branchBlock(input logic [5:0] op, input regIndex rs, input regIndex rt,
                             input word x, input word y, input int base, input word val);
    bit taken;
    taken = (op == opBne) ? (x != y) : (x == y);
    emit(iType(op, rt, rs, 16'd3));              // Target is 3 words past the branch
    storeWord(5'd1, base);
    expectStore(base, val);
    storeWord(5'd1, base + 4);
    if (!taken) expectStore(base + 4, val);
    storeWord(5'd1, base + 8);
    expectStore(base + 8, val);
  endtask

  task automatic branchPaths();
    word a;
    word b;
    startTest();
    a = $urandom;
    b = $urandom;
    if (b == a) b = ~a;
    ram[0] <= a;
    ram[1] <= b;
    ram[2] <= a;
    loadWord(5'd1, 0);
    loadWord(5'd2, 4);
    loadWord(5'd3, 8);
    branchBlock(opBeq, 5'd1, 5'd3, a, a, 'h40, a);
    branchBlock(opBeq, 5'd1, 5'd2, a, b, 'h50, a);
    branchBlock(opBne, 5'd1, 5'd2, a, b, 'h60, a);
    branchBlock(opBne, 5'd1, 5'd3, a, a, 'h70, a);
    emit(iType(opAddi, 5'd4, 5'd1, 16'd0));      // Operand from the ALU just before
    branchBlock(opBeq, 5'd4, 5'd1, a, a, 'h80, a);
    loadWord(5'd5, 4);                           // Operand from a load
    branchBlock(opBne, 5'd5, 5'd2, b, b, 'h90, a);
    runProgram();
  endtask

  task automatic jumpAndZeroReg();
    word a;
    startTest();
    a = $urandom;
    ram[0] <= a;
    loadWord(5'd1, 0);
    emit(iType(opAddi, 5'd0, 5'd1, 16'h0005));   // Discarded
    storeWord(5'd0, 'h40);
    expectStore('h40, 32'h0);
    emit(jType(emitIdx + 4));
    storeWord(5'd1, 'h44);                       // Delay slot
    expectStore('h44, a);
    storeWord(5'd1, 'h48);
    storeWord(5'd1, 'h4C);
    emit(rType(functAdd, 5'd0, 5'd1, 5'd1));
    storeWord(5'd0, 'h50);
    expectStore('h50, 32'h0);
    runProgram();
  endtask

  //----------------------------------------------------------
  // Sequence and watchdog
  //----------------------------------------------------------
  initial begin
    restart   = 1'b0;
    doneSeen  = 1'b0;
    emitIdx   = 0;
    void'($urandom(32'h78da_afe4));
    clearMemories();
    rtypeAluOps();
    immediateOps();
    forwardingChains();
    branchPaths();
    jumpAndZeroReg();
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    repeat (testCount * (cyclesPerTest + 8)) @(posedge clk);
    $display("Watchdog expired, a program never reached its final store");
    $display("Finished with errors");
    $fatal(1, "Timeout");
  end

endmodule

// ==== filelist.f ====
hdl/mipsPkg.sv
hdl/controlDecoder.sv
hdl/registerFile.sv
hdl/hazardUnit.sv
hdl/fetchDecodeStage.sv
hdl/executeStage.sv
hdl/memWritebackStage.sv
hdl/mipsCore.sv
testbench/tbClock.sv
testbench/mipsTb.sv

// ==== Makefile ====
# Verilator build and run for the MIPS core testbench

VERILATOR ?= verilator
TOP       ?= mipsTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "Finished with no errors" $(LOG)
	@! grep -q "Finished with errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
